/* src/pmul_pkg.sv */
/* Shared definitions for the packed-SIMD multiplier
   Operation codes, kernel modes, result selects, stage payload structs */

package pmul_pkg;

  localparam int unsigned XLEN   = 32;
  localparam int unsigned BYTE_W = 8;
  // Width of one 9x9 signed kernel product
  localparam int unsigned KER_W  = 18;

  typedef enum logic [4:0] {
    OP_Q7_MUL       = 5'd0,
    OP_Q7_MUL_X     = 5'd1,
    OP_Q15_MUL      = 5'd2,
    OP_Q15_MUL_X    = 5'd3,
    OP_MUL16_BB     = 5'd4,
    OP_MUL16_BT     = 5'd5,
    OP_MUL16_TT     = 5'd6,
    OP_DOT16_ADD    = 5'd7,
    OP_DOT16_ADD_X  = 5'd8,
    OP_DOT16_SUB    = 5'd9,
    OP_DOT16_SUB_R  = 5'd10,
    OP_DOT16_SUB_X  = 5'd11,
    OP_DOT8_ACC_SS  = 5'd12,
    OP_DOT8_ACC_UU  = 5'd13,
    OP_DOT8_ACC_SU  = 5'd14,
    OP_MULH32X16_B  = 5'd15,
    OP_MULH32X16_T  = 5'd16,
    OP_MACH32X16_B  = 5'd17,
    OP_MACH32X16_T  = 5'd18
  } pmul_op_e;

  // How the two 16x16 kernels are arranged
  typedef enum logic [1:0] {
    M8X8,
    M16X16,
    M32X16
  } mult_mode_e;

  typedef enum logic [2:0] {
    RES_Q7,
    RES_Q15,
    RES_P16_LO,
    RES_P16_HI,
    RES_DOT16,
    RES_ACCUM,
    RES_MUL32X16
  } res_sel_e;

  typedef logic [3:0][BYTE_W-1:0] byte_lanes_t;

  typedef struct packed {
    mult_mode_e mode;
    res_sel_e   res_sel;
    logic       crossed;
    logic [1:0] accum_sub;
    logic       dsum;
    logic       top_top;
    logic       reversed;
    logic       dot8_signed;
  } pmul_ctl_s;

  // Stage 1 to stage 2
  typedef struct packed {
    logic            valid;
    pmul_ctl_s       ctl;
    byte_lanes_t     a;
    byte_lanes_t     b;
    logic [3:0]      a_sign;
    logic [3:0]      b_sign;
    logic [3:0]      sat;
    logic [XLEN-1:0] rd;
  } dec_s;

  // Stage 2 to stage 3
  typedef struct packed {
    logic                   valid;
    pmul_ctl_s              ctl;
    logic [7:0][KER_W-1:0]  prod;
    logic [3:0]             sat;
    logic [XLEN-1:0]        rd;
  } kern_s;

endpackage

/* src/pmul_decode_stage.sv */
/* Multiplier stage 1
   Operation decode, b lane steering, per-byte sign bits, saturation detect */

`timescale 1ns/1ps

module pmul_decode_stage import pmul_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            valid_i,
  input  pmul_op_e        op_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  input  logic [XLEN-1:0] rd_i,
  output dec_s            dec_o
);

  pmul_ctl_s   ctl;
  logic [1:0]  quadrant;
  logic        a_signed, b_signed;
  byte_lanes_t a_lanes, b_lanes, b_cross;
  logic [3:0]  a_sign, b_sign;
  logic [3:0]  sat8, sat;
  logic [1:0]  sat16;

  //////////////////////////////////////////////////////////////////////
  // Operation decode
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    ctl = '0;
    unique case (op_i)
      OP_Q7_MUL, OP_Q7_MUL_X: begin
        ctl.mode    = M8X8;
        ctl.res_sel = RES_Q7;
      end
      OP_Q15_MUL, OP_Q15_MUL_X: begin
        ctl.mode    = M16X16;
        ctl.res_sel = RES_Q15;
      end
      OP_MUL16_BB, OP_MUL16_BT: begin
        ctl.mode    = M16X16;
        ctl.res_sel = RES_P16_LO;
      end
      OP_MUL16_TT: begin
        ctl.mode    = M16X16;
        ctl.res_sel = RES_P16_HI;
      end
      OP_DOT8_ACC_SS, OP_DOT8_ACC_UU, OP_DOT8_ACC_SU: begin
        ctl.mode    = M8X8;
        ctl.res_sel = RES_ACCUM;
      end
      OP_MULH32X16_B, OP_MULH32X16_T: begin
        ctl.mode    = M32X16;
        ctl.res_sel = RES_MUL32X16;
      end
      OP_MACH32X16_B, OP_MACH32X16_T: begin
        ctl.mode    = M32X16;
        ctl.res_sel = RES_ACCUM;
      end
      // Two-halfword dot forms
      default: begin
        ctl.mode    = M16X16;
        ctl.res_sel = RES_DOT16;
      end
    endcase

    ctl.crossed      = op_i inside {OP_Q7_MUL_X, OP_Q15_MUL_X, OP_MUL16_BT, OP_DOT16_ADD_X,
                                    OP_DOT16_SUB_X, OP_MULH32X16_T, OP_MACH32X16_T};
    ctl.accum_sub[0] = op_i inside {OP_DOT16_SUB, OP_DOT16_SUB_X};
    // No kept operation subtracts from rd
    ctl.accum_sub[1] = 1'b0;
    ctl.dsum         = op_i inside {OP_DOT16_ADD, OP_DOT16_ADD_X, OP_DOT16_SUB,
                                    OP_DOT16_SUB_R, OP_DOT16_SUB_X};
    ctl.top_top      = (op_i == OP_MUL16_TT);
    ctl.reversed     = (op_i == OP_DOT16_SUB_R);
    ctl.dot8_signed  = op_i inside {OP_DOT8_ACC_SS, OP_DOT8_ACC_SU};
  end

  // Which b half feeds each kernel
  always_comb begin
    unique case (ctl.mode)
      M16X16:  quadrant = ctl.crossed ? 2'b11 : 2'b00;
      M32X16:  quadrant = ctl.crossed ? 2'b01 : 2'b10;
      default: quadrant = 2'b00;
    endcase
  end

  assign a_lanes    = op_a_i;
  assign b_lanes[0] = quadrant[0] ? op_b_i[23:16] : op_b_i[7:0];
  assign b_lanes[1] = quadrant[0] ? op_b_i[31:24] : op_b_i[15:8];
  assign b_lanes[2] = quadrant[1] ? op_b_i[7:0]   : op_b_i[23:16];
  assign b_lanes[3] = quadrant[1] ? op_b_i[15:8]  : op_b_i[31:24];

  // Bytes swapped within each halfword, as a crossed Q7 lane sees them
  assign b_cross = {b_lanes[2], b_lanes[3], b_lanes[0], b_lanes[1]};

  //////////////////////////////////////////////////////////////////////
  // Sign bits
  //////////////////////////////////////////////////////////////////////
  // Only byte mode has unsigned forms
  assign a_signed = (ctl.res_sel == RES_Q7) | ctl.dot8_signed;
  assign b_signed = (ctl.res_sel == RES_Q7) | (op_i == OP_DOT8_ACC_SS);

  always_comb begin
    unique case (ctl.mode)
      M8X8: begin
        a_sign = {a_lanes[3][7], a_lanes[2][7], a_lanes[1][7], a_lanes[0][7]} & {4{a_signed}};
        b_sign = {b_lanes[3][7], b_lanes[2][7], b_lanes[1][7], b_lanes[0][7]} & {4{b_signed}};
      end
      M16X16: begin
        a_sign = {a_lanes[3][7], 1'b0, a_lanes[1][7], 1'b0};
        b_sign = {b_lanes[3][7], 1'b0, b_lanes[1][7], 1'b0};
      end
      // Low word of a is unsigned, both kernels share one b half
      default: begin
        a_sign = {a_lanes[3][7], 3'b000};
        b_sign = {b_lanes[1][7], 1'b0, b_lanes[1][7], 1'b0};
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Saturation detect
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      sat8[i] = (a_lanes[i] == 8'h80) && ((ctl.crossed ? b_cross[i] : b_lanes[i]) == 8'h80);
    end
  end

  assign sat16[0] = (op_a_i[15:0] == 16'h8000) && ({b_lanes[1], b_lanes[0]} == 16'h8000);
  assign sat16[1] = (op_a_i[31:16] == 16'h8000) && ({b_lanes[3], b_lanes[2]} == 16'h8000);

  always_comb begin
    unique case (ctl.mode)
      M8X8:    sat = sat8;
      M16X16:  sat = {{2{sat16[1]}}, {2{sat16[0]}}};
      default: sat = 4'b0000;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_o <= '0;
    end else begin
      dec_o.valid  <= valid_i;
      dec_o.ctl    <= ctl;
      dec_o.a      <= a_lanes;
      dec_o.b      <= b_lanes;
      dec_o.a_sign <= a_sign;
      dec_o.b_sign <= b_sign;
      dec_o.sat    <= sat;
      dec_o.rd     <= rd_i;
    end
  end

endmodule

/* src/pmul_kernel_stage.sv */
/* Multiplier stage 2
   Eight 9x9 signed byte multipliers forming two 16x16 kernels */

`timescale 1ns/1ps

module pmul_kernel_stage import pmul_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  dec_s  dec_i,
  output kern_s kern_o
);

  logic [3:0][KER_W-1:0] a_ext, b_ext;
  logic [7:0][KER_W-1:0] prod;

  //////////////////////////////////////////////////////////////////////
  // Operand extension
  //////////////////////////////////////////////////////////////////////
  // Each byte carries its own sign bit from stage 1, so one multiplier
  // serves signed, unsigned and mixed lanes alike
  always_comb begin
    for (int l = 0; l < 4; l++) begin
      a_ext[l] = {{(KER_W-BYTE_W){dec_i.a_sign[l]}}, dec_i.a[l]};
      b_ext[l] = {{(KER_W-BYTE_W){dec_i.b_sign[l]}}, dec_i.b[l]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Kernel multipliers
  //////////////////////////////////////////////////////////////////////
  // Product index is 4*kernel + 2*a_byte + b_byte
  //   0  a0 x b0
  //   1  a0 x b1
  //   2  a1 x b0
  //   3  a1 x b1
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      for (int i = 0; i < 2; i++) begin
        for (int j = 0; j < 2; j++) begin
          prod[4*k + 2*i + j] = $signed(a_ext[2*k + i]) * $signed(b_ext[2*k + j]);
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      kern_o <= '0;
    end else begin
      kern_o.valid <= dec_i.valid;
      kern_o.ctl   <= dec_i.ctl;
      kern_o.prod  <= prod;
      kern_o.sat   <= dec_i.sat;
      kern_o.rd    <= dec_i.rd;
    end
  end

endmodule

/* src/pmul_reduce_stage.sv */
/* Multiplier stage 3
   Kernel reduction adders, dot sums, rd accumulator, saturation override
   and the registered result mux */

`timescale 1ns/1ps

module pmul_reduce_stage import pmul_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  kern_s           kern_i,
  output logic            valid_o,
  output logic [XLEN-1:0] result_o,
  output logic            ov_o
);

  pmul_ctl_s              ctl;
  logic [3:0]             sat;
  logic [XLEN-1:0]        ker0, ker1;
  logic [47:0]            prod48;
  logic [XLEN-1:0]        mulh;
  logic [XLEN-1:0]        term0, term1, dot16;
  logic [XLEN-1:0]        dot8;
  logic [XLEN-1:0]        acc_opnd, acc;
  logic [3:0][BYTE_W-1:0] q7;
  logic [XLEN-1:0]        q15;
  logic [XLEN-1:0]        result_d;
  logic                   ov_d;

  function automatic logic [XLEN-1:0] sext_prod(input logic [KER_W-1:0] p);
    return {{(XLEN-KER_W){p[KER_W-1]}}, p};
  endfunction

  // One 16x16 product from the four byte products of a kernel
  function automatic logic [XLEN-1:0] kern16(input logic [3:0][KER_W-1:0] p);
    logic [XLEN-1:0] lo, mid, hi;
    lo  = sext_prod(p[0]);
    mid = sext_prod(p[1]) + sext_prod(p[2]);
    hi  = sext_prod(p[3]);
    return lo + (mid << 8) + (hi << 16);
  endfunction

  assign ctl = kern_i.ctl;
  assign sat = kern_i.sat;

  //////////////////////////////////////////////////////////////////////
  // Kernel and 32x16 adders
  //////////////////////////////////////////////////////////////////////
  assign ker0 = kern16(kern_i.prod[3:0]);
  assign ker1 = kern16(kern_i.prod[7:4]);

  // Upper kernel holds the signed top word of a
  assign prod48 = {ker1, 16'h0000} + {{16{ker0[31]}}, ker0};
  assign mulh   = prod48[47:16];

  //////////////////////////////////////////////////////////////////////
  // Dot sums and rd accumulator
  //////////////////////////////////////////////////////////////////////
  assign term0 = ctl.accum_sub[0] ? -ker0 : ker0;
  assign term1 = ctl.reversed ? -ker1 : ker1;
  assign dot16 = term0 + term1;

  // Straight byte pairs only
  assign dot8 = sext_prod(kern_i.prod[0]) + sext_prod(kern_i.prod[3]) +
                sext_prod(kern_i.prod[4]) + sext_prod(kern_i.prod[7]);

  always_comb begin
    unique case (ctl.mode)
      M8X8:    acc_opnd = dot8;
      default: acc_opnd = mulh;
    endcase
  end

  assign acc = kern_i.rd + (ctl.accum_sub[1] ? -acc_opnd : acc_opnd);

  //////////////////////////////////////////////////////////////////////
  // Fixed-point lanes with saturation
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    q7[0] = ctl.crossed ? kern_i.prod[1][14:7] : kern_i.prod[0][14:7];
    q7[1] = ctl.crossed ? kern_i.prod[2][14:7] : kern_i.prod[3][14:7];
    q7[2] = ctl.crossed ? kern_i.prod[5][14:7] : kern_i.prod[4][14:7];
    q7[3] = ctl.crossed ? kern_i.prod[6][14:7] : kern_i.prod[7][14:7];
    for (int i = 0; i < 4; i++) begin
      if (sat[i]) begin
        q7[i] = 8'h7f;
      end
    end
  end

  assign q15 = {sat[3] ? 16'h7fff : ker1[30:15],
                sat[1] ? 16'h7fff : ker0[30:15]};

  // Result mux
  always_comb begin
    unique case (ctl.res_sel)
      RES_Q7:       result_d = q7;
      RES_Q15:      result_d = q15;
      RES_P16_LO:   result_d = ker0;
      RES_P16_HI:   result_d = ker1;
      RES_DOT16:    result_d = dot16;
      RES_ACCUM:    result_d = acc;
      RES_MUL32X16: result_d = mulh;
      default:      result_d = '0;
    endcase
  end

  assign ov_d = (ctl.res_sel inside {RES_Q7, RES_Q15}) && (|sat);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o  <= 1'b0;
      ov_o     <= 1'b0;
      result_o <= '0;
    end else begin
      valid_o <= kern_i.valid;
      ov_o    <= kern_i.valid & ov_d;
      // Result holds between operations
      if (kern_i.valid) begin
        result_o <= result_d;
      end
    end
  end

endmodule

/* src/pmul_top.sv */
/* Packed-SIMD multiplier top level
   Three-stage pipeline of decode, kernel and reduce stages */

`timescale 1ns/1ps

module pmul_top import pmul_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,

  input  logic            valid_i,
  input  pmul_op_e        op_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  input  logic [XLEN-1:0] rd_i,

  output logic            valid_o,
  output logic [XLEN-1:0] result_o,
  output logic            ov_o
);

  // Stage payloads
  dec_s  dec;
  kern_s kern;

  pmul_decode_stage u_decode (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (valid_i),
    .op_i    (op_i),
    .op_a_i  (op_a_i),
    .op_b_i  (op_b_i),
    .rd_i    (rd_i),
    .dec_o   (dec)
  );

  pmul_kernel_stage u_kernel (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .dec_i  (dec),
    .kern_o (kern)
  );

  pmul_reduce_stage u_reduce (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .kern_i   (kern),
    .valid_o  (valid_o),
    .result_o (result_o),
    .ov_o     (ov_o)
  );

endmodule

/* bench/pmul_model.svh */
/* Reference model for the packed-SIMD multiplier
   Expected result and overflow flag for each operation code */

`ifndef PMUL_MODEL_SVH
`define PMUL_MODEL_SVH

typedef struct packed {
  pmul_op_e        op;
  logic [XLEN-1:0] result;
  logic            ov;
} expect_s;

// Fixed-point lane, pinned to the largest positive value when both
// inputs are the most negative one
function automatic int q_lane(input int x, input int y, input int frac, output logic sat);
  sat = (x == -(1 << frac)) && (y == -(1 << frac));
  if (sat) begin
    return (1 << frac) - 1;
  end
  return (x * y) >>> frac;
endfunction

function automatic int byte_val(input logic [7:0] x, input logic is_signed);
  return is_signed ? int'($signed(x)) : int'(x);
endfunction

function automatic expect_s model_op(input pmul_op_e op, input logic [XLEN-1:0] a,
                                     input logic [XLEN-1:0] b, input logic [XLEN-1:0] rd);
  expect_s            e;
  logic [XLEN-1:0]    bsel;
  logic [7:0]         bb;
  logic [15:0]        bh;
  logic               s;
  int                 lane, alo, ahi, blo, bhi, dot;
  logic signed [47:0] wide;
  e    = '0;
  e.op = op;
  // Crossed halfword forms see b with its halves swapped
  bsel = (op inside {OP_Q15_MUL_X, OP_DOT16_ADD_X, OP_DOT16_SUB_X}) ?
         {b[15:0], b[31:16]} : b;
  alo  = int'($signed(a[15:0]));
  ahi  = int'($signed(a[31:16]));
  blo  = int'($signed(bsel[15:0]));
  bhi  = int'($signed(bsel[31:16]));
  case (op)
    OP_Q7_MUL, OP_Q7_MUL_X: begin
      for (int i = 0; i < 4; i++) begin
        bb   = (op == OP_Q7_MUL_X) ? b[8*(i^1) +: 8] : b[8*i +: 8];
        lane = q_lane(int'($signed(a[8*i +: 8])), int'($signed(bb)), 7, s);
        e.result[8*i +: 8] = lane[7:0];
        e.ov = e.ov | s;
      end
    end
    OP_Q15_MUL, OP_Q15_MUL_X: begin
      for (int i = 0; i < 2; i++) begin
        bh   = bsel[16*i +: 16];
        lane = q_lane(int'($signed(a[16*i +: 16])), int'($signed(bh)), 15, s);
        e.result[16*i +: 16] = lane[15:0];
        e.ov = e.ov | s;
      end
    end
    OP_MUL16_BB:                    e.result = alo * blo;
    OP_MUL16_BT:                    e.result = alo * bhi;
    OP_MUL16_TT:                    e.result = ahi * bhi;
    OP_DOT16_ADD, OP_DOT16_ADD_X:   e.result = ahi * bhi + alo * blo;
    OP_DOT16_SUB, OP_DOT16_SUB_X:   e.result = ahi * bhi - alo * blo;
    OP_DOT16_SUB_R:                 e.result = alo * blo - ahi * bhi;
    OP_DOT8_ACC_SS, OP_DOT8_ACC_UU, OP_DOT8_ACC_SU: begin
      dot = 0;
      for (int i = 0; i < 4; i++) begin
        dot += byte_val(a[8*i +: 8], op != OP_DOT8_ACC_UU) *
               byte_val(b[8*i +: 8], op == OP_DOT8_ACC_SS);
      end
      e.result = rd + dot;
    end
    // 32x16 high word, plain or accumulated
    default: begin
      bh       = (op inside {OP_MULH32X16_T, OP_MACH32X16_T}) ? b[31:16] : b[15:0];
      wide     = 48'($signed(a)) * 48'($signed(bh));
      e.result = wide[47:16];
      if (op inside {OP_MACH32X16_B, OP_MACH32X16_T}) begin
        e.result = rd + wide[47:16];
      end
    end
  endcase
  return e;
endfunction

`endif

/* bench/tb_pmul.sv */
/* Testbench for the packed-SIMD multiplier
   Clock and reset, directed and random stimulus, output checks, watchdog */

`timescale 1ns/1ps

module tb_pmul import pmul_pkg::*; ();

  `include "pmul_model.svh"

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 3;
  localparam int N_RANDOM     = 190;
  // Latency, random, saturation, dot8, 16x16, 32x16
  localparam int N_GROUPS     = 6;
  localparam int N_OPS        = 1 + N_RANDOM + 8 + 7 + 8 + 8;
  // Every group drains the pipeline before the next one starts
  localparam int WATCHDOG_CYCLES = N_OPS + 20 + RESET_CYCLES + 8 * N_GROUPS;

  logic            clk = 1'b0;
  logic            rst_n;
  logic            in_valid;
  pmul_op_e        in_op;
  logic [XLEN-1:0] in_a, in_b, in_rd;
  logic            out_valid;
  logic [XLEN-1:0] out_result;
  logic            out_ov;

  expect_s         exp_q[$];
  logic [XLEN-1:0] last_result = '0;
  int              n_issued = 0;
  int              n_checked = 0;

  pmul_top DUT (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .valid_i  (in_valid),
    .op_i     (in_op),
    .op_a_i   (in_a),
    .op_b_i   (in_b),
    .rd_i     (in_rd),
    .valid_o  (out_valid),
    .result_o (out_result),
    .ov_o     (out_ov)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic issue(input pmul_op_e code, input logic [XLEN-1:0] a,
                       input logic [XLEN-1:0] b, input logic [XLEN-1:0] rd);
    @(negedge clk);
    in_valid = 1'b1;
    in_op    = code;
    in_a     = a;
    in_b     = b;
    in_rd    = rd;
    exp_q.push_back(model_op(code, a, b, rd));
    n_issued++;
  endtask

  // Idle the input and wait for every result in flight
  task automatic drain();
    @(negedge clk);
    in_valid = 1'b0;
    while (n_checked != n_issued) @(posedge clk);
  endtask

  function automatic logic [XLEN-1:0] pick_operand();
    logic [XLEN-1:0] w;
    case ($urandom_range(3))
      0:       w = 32'h8080_8080;
      1:       w = 32'h8000_8000;
      default: w = $urandom();
    endcase
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Output checks
  //////////////////////////////////////////////////////////////////////
  always @(negedge clk) begin : check_outputs
    expect_s head;
    assert (out_valid || !out_ov)
      else fail_run($sformatf("ERROR at time %0t: ov_o high while valid_o is low", $time));
    if (out_valid) begin
      assert (exp_q.size() > 0)
        else fail_run("A result came out with no operation in flight");
      head = exp_q.pop_front();
      assert (out_result == head.result)
        else fail_run($sformatf("ERROR at time %0t: %s result 0x%08h, expected 0x%08h",
                                $time, head.op.name(), out_result, head.result));
      assert (out_ov == head.ov)
        else fail_run($sformatf("ERROR at time %0t: %s ov_o %0b, expected %0b",
                                $time, head.op.name(), out_ov, head.ov));
      last_result = out_result;
      n_checked++;
    end else begin
      assert (out_result == last_result)
        else fail_run($sformatf("ERROR at time %0t: result_o moved to 0x%08h with valid_o low",
                                $time, out_result));
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_run("Timeout: the pipeline did not return all results in time");
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////
  initial begin
    in_valid = 1'b0;
    in_op    = OP_Q7_MUL;
    in_a     = '0;
    in_b     = '0;
    in_rd    = '0;
    void'($urandom(32'h8e50));
    // Reset edge just after time zero
    rst_n = 1'b1;
    #1 rst_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // Quiet outputs, then one operation with its exact latency
    repeat (2) @(negedge clk);
    issue(OP_MUL16_BB, 32'h0003_fffb, 32'h0007_8001, '0);
    for (int c = 1; c <= 3; c++) begin
      @(negedge clk);
      in_valid = 1'b0;
      assert (out_valid == (c == 3))
        else fail_run($sformatf("ERROR at time %0t: valid_o=%0b %0d cycles after first issue",
                                $time, out_valid, c));
    end
    drain();

    // Every code back to back
    for (int i = 0; i < N_RANDOM; i++) begin
      issue(pmul_op_e'(5'(i % 19)), pick_operand(), pick_operand(), $urandom());
    end
    drain();

    // Saturating lanes mixed with normal ones
    issue(OP_Q7_MUL,    32'h8040_8080, 32'h8040_7f80, '0);
    issue(OP_Q7_MUL_X,  32'h0080_8000, 32'h8000_0080, '0);
    issue(OP_Q7_MUL,    32'h7f7f_8080, 32'h7f80_7f01, '0);
    issue(OP_Q15_MUL,   32'h8000_1234, 32'h8000_8000, '0);
    issue(OP_Q15_MUL_X, 32'h4000_8000, 32'h8000_7fff, '0);
    issue(OP_Q15_MUL,   32'h8000_8000, 32'h8000_8000, '0);
    issue(OP_Q15_MUL_X, 32'h8000_8000, 32'h7fff_7fff, '0);
    issue(OP_MUL16_BB,  32'h8000_8000, 32'h8000_8000, '0);
    drain();

    // Four-byte accumulate at the extremes
    issue(OP_DOT8_ACC_SS, 32'h8080_8080, 32'h8080_8080, 32'h7fff_ffff);
    issue(OP_DOT8_ACC_SS, 32'h8080_8080, 32'h7f7f_7f7f, 32'h8000_0000);
    issue(OP_DOT8_ACC_UU, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff);
    issue(OP_DOT8_ACC_UU, 32'hff00_ff80, 32'h80ff_01ff, 32'h8000_0000);
    issue(OP_DOT8_ACC_SU, 32'h8080_8080, 32'hffff_ffff, 32'h0000_0000);
    issue(OP_DOT8_ACC_SU, 32'h7f7f_7f7f, 32'hffff_ffff, 32'h7fff_ffff);
    issue(OP_DOT8_ACC_SS, 32'h01ff_7f80, 32'hff01_7f80, 32'h0000_0000);
    drain();

    // 16x16 products and dot forms at the sign boundary
    issue(OP_MUL16_BB,    32'h8000_8000, 32'h7fff_8000, '0);
    issue(OP_MUL16_BT,    32'h0001_8000, 32'h8000_0001, '0);
    issue(OP_MUL16_TT,    32'h8000_7fff, 32'h8000_ffff, '0);
    issue(OP_DOT16_ADD,   32'h8000_8000, 32'h8000_8000, '0);
    issue(OP_DOT16_ADD_X, 32'h7fff_8000, 32'h8000_7fff, '0);
    issue(OP_DOT16_SUB,   32'h8000_7fff, 32'h8000_8000, '0);
    issue(OP_DOT16_SUB_R, 32'h8000_7fff, 32'h8000_8000, '0);
    issue(OP_DOT16_SUB_X, 32'hffff_8000, 32'h8000_0001, '0);
    drain();

    // 32x16 high word
    issue(OP_MULH32X16_B, 32'h8000_0000, 32'h0000_8000, '0);
    issue(OP_MULH32X16_T, 32'h8000_0000, 32'h8000_0000, '0);
    issue(OP_MULH32X16_B, 32'h7fff_ffff, 32'hffff_7fff, '0);
    issue(OP_MULH32X16_T, 32'hffff_ffff, 32'h7fff_0001, '0);
    issue(OP_MACH32X16_B, 32'h8000_0000, 32'h1234_8000, 32'h7fff_ffff);
    issue(OP_MACH32X16_T, 32'h1234_5678, 32'h8000_1234, 32'h8000_0000);
    issue(OP_MACH32X16_B, 32'h0000_ffff, 32'h0000_ffff, 32'hffff_ffff);
    issue(OP_MACH32X16_T, 32'h8000_ffff, 32'hffff_0000, 32'h0000_0001);
    drain();

    $display("Everything OK");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+bench
src/pmul_pkg.sv
src/pmul_decode_stage.sv
src/pmul_kernel_stage.sv
src/pmul_reduce_stage.sv
src/pmul_top.sv
bench/tb_pmul.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the packed-SIMD multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f vlog.f --top-module tb_pmul -o tb_pmul
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/tb_pmul 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "Everything OK"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi
